// File: riscvPkg.sv
`default_nettype none

package riscvPkg;

    localparam int xlen     = 32;  // data path width
    localparam int regAddrW = 5;   // register index width, 32 architectural regs

    // major opcode field, instr[6:0]
    // only the legal RV32I classes are listed, others fall to a decoder default
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,  // lb, lh, lw, lbu, lhu
        STORE  = 7'b0100011,  // sb, sh, sw
        OP     = 7'b0110011,  // register-register alu ops
        BRANCH = 7'b1100011,  // beq .. bgeu
        OPIMM  = 7'b0010011,  // register-immediate alu ops
        AUIPC  = 7'b0010111,  // add upper imm to pc
        LUI    = 7'b0110111,  // load upper imm
        JAL    = 7'b1101111,  // jump and link
        JALR   = 7'b1100111   // jump and link register
    } opcodeT;

    // immediate format picked by the main decoder
    typedef enum logic [1:0] {
        IMM_I = 2'b00,  // 12 bit signed, loads and alu imm
        IMM_S = 2'b01,  // split store offset
        IMM_B = 2'b10,  // branch offset, lsb zero
        IMM_U = 2'b11   // upper 20 bits
    } immSrcT;

    // coarse alu class from the main decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,  // address calc and upper imm
        ALUOP_SUB   = 2'b01,  // branch compare
        ALUOP_FUNCT = 2'b10   // look at funct3 / funct7
    } aluOpT;

    // operation handed to the execute stage alu
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } aluCtrlT;

endpackage

`default_nettype wire

// File: mainDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    input  logic [6:0]        opcode,     // instr[6:0]
    output logic              resultSrc,  // 1 = write back load data
    output logic              memWrite,   // store enable
    output logic              aluSrc,     // 1 = immediate as second operand
    output logic              regWrite,   // register file write enable
    output logic              branch,     // conditional branch
    output riscvPkg::immSrcT  immSrc,     // immediate format
    output riscvPkg::aluOpT   aluOp       // coarse alu class
);
    import riscvPkg::*;

    always_comb begin
        case (opcodeT'(opcode))  // illegal encodings land in default
            LOAD: begin
                resultSrc = 1'b1;       // data comes from memory
                memWrite  = 1'b0;
                aluSrc    = 1'b1;       // base + offset
                regWrite  = 1'b1;
                branch    = 1'b0;
                immSrc    = IMM_I;
                aluOp     = ALUOP_ADD;
            end
            STORE: begin
                resultSrc = 1'b0;       // unused, no write back
                memWrite  = 1'b1;
                aluSrc    = 1'b1;
                regWrite  = 1'b0;
                branch    = 1'b0;
                immSrc    = IMM_S;
                aluOp     = ALUOP_ADD;
            end
            OP: begin
                resultSrc = 1'b0;
                memWrite  = 1'b0;
                aluSrc    = 1'b0;       // both operands from regs
                regWrite  = 1'b1;
                branch    = 1'b0;
                immSrc    = IMM_I;      // don't care
                aluOp     = ALUOP_FUNCT;
            end
            BRANCH: begin
                resultSrc = 1'b0;       // don't care
                memWrite  = 1'b0;
                aluSrc    = 1'b0;
                regWrite  = 1'b0;
                branch    = 1'b1;
                immSrc    = IMM_B;
                aluOp     = ALUOP_SUB;  // compare by subtraction
            end
            OPIMM: begin
                resultSrc = 1'b0;
                memWrite  = 1'b0;
                aluSrc    = 1'b1;
                regWrite  = 1'b1;
                branch    = 1'b0;
                immSrc    = IMM_I;
                aluOp     = ALUOP_FUNCT;
            end
            AUIPC, LUI: begin           // both U-type, same control word
                resultSrc = 1'b0;
                memWrite  = 1'b0;
                aluSrc    = 1'b1;
                regWrite  = 1'b1;
                branch    = 1'b0;
                immSrc    = IMM_U;
                aluOp     = ALUOP_ADD;
            end
            JAL, JALR: begin
                // jumps look like a plain register write here
                // the jump path itself lives in the fetch stage
                resultSrc = 1'b0;
                memWrite  = 1'b0;
                aluSrc    = 1'b1;
                regWrite  = 1'b1;
                branch    = 1'b0;
                immSrc    = IMM_I;      // no J format built
                aluOp     = ALUOP_ADD;
            end
            default: begin              // all-zero control word
                resultSrc = 1'b0;
                memWrite  = 1'b0;
                aluSrc    = 1'b0;
                regWrite  = 1'b0;
                branch    = 1'b0;
                immSrc    = IMM_I;
                aluOp     = ALUOP_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
    input  riscvPkg::aluOpT   aluOp,     // class from the main decoder
    input  logic [2:0]        funct3,    // instr[14:12]
    input  logic              funct7b5,  // instr[30]
    input  logic              opb5,      // instr[5], 1 for R-type
    output riscvPkg::aluCtrlT aluCtrl    // alu operation
);
    import riscvPkg::*;

    logic rTypeSub;  // sub only exists in the register form

    assign rTypeSub = funct7b5 & opb5;

    always_comb begin
        case (aluOp)
            ALUOP_ADD: aluCtrl = ALU_ADD;  // loads, stores, upper imm
            ALUOP_SUB: aluCtrl = ALU_SUB;  // branches
            ALUOP_FUNCT: begin
                case (funct3)
                    3'b000: begin
                        // addi with instr[30] set is still an add
                        if (rTypeSub) begin
                            aluCtrl = ALU_SUB;
                        end else begin
                            aluCtrl = ALU_ADD;
                        end
                    end
                    3'b001: aluCtrl = ALU_SLL;
                    3'b010: aluCtrl = ALU_SLT;
                    3'b011: aluCtrl = ALU_SLTU;
                    3'b100: aluCtrl = ALU_XOR;
                    3'b101: begin
                        if (funct7b5) begin   // arithmetic shift, reg and imm forms
                            aluCtrl = ALU_SRA;
                        end else begin
                            aluCtrl = ALU_SRL;
                        end
                    end
                    3'b110: aluCtrl = ALU_OR;
                    default: aluCtrl = ALU_AND;  // 3'b111
                endcase
            end
            default: aluCtrl = ALU_ADD;  // unused aluOp code 11
        endcase
    end

endmodule

`default_nettype wire

// File: immExtend.sv
`timescale 1ns/1ps
`default_nettype none

module immExtend #(
    parameter int dataWidth = riscvPkg::xlen  // width of the built immediate
) (
    input  logic [dataWidth-1:0] instr,   // full instruction word
    input  riscvPkg::immSrcT     immSrc,  // format select
    output logic [dataWidth-1:0] imm      // extended immediate
);
    import riscvPkg::*;

    logic [11:0] iField;  // raw I offset
    logic [11:0] sField;  // store offset, split in the word
    logic [12:0] bField;  // branch offset incl. zero lsb
    logic [31:0] uField;  // upper imm, low 12 bits zero

    assign iField = instr[31:20];
    assign sField = {instr[31:25], instr[11:7]};
    assign bField = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign uField = {instr[31:12], 12'b0};

    // size casts of signed values replicate the top bit
    always_comb begin
        case (immSrc)
            IMM_I:   imm = dataWidth'($signed(iField));
            IMM_S:   imm = dataWidth'($signed(sField));
            IMM_B:   imm = dataWidth'($signed(bField));
            default: imm = dataWidth'($signed(uField));  // IMM_U
        endcase
    end

endmodule

`default_nettype wire

// File: idExReg.sv
`timescale 1ns/1ps
`default_nettype none

module idExReg #(
    parameter int dataWidth    = riscvPkg::xlen,     // immediate width
    parameter int regAddrWidth = riscvPkg::regAddrW  // register index width
) (
    input  logic                    clk,
    input  logic                    arstN,        // async, active low
    input  logic                    stall,        // hold everything
    input  logic                    flush,        // kill the slot, beats stall
    input  logic                    inValid,      // decode slot holds an instruction
    input  logic                    resultSrc,
    input  logic                    memWrite,
    input  logic                    aluSrc,
    input  logic                    regWrite,
    input  logic                    branch,
    input  riscvPkg::aluCtrlT       aluCtrl,
    input  logic [dataWidth-1:0]    imm,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [regAddrWidth-1:0] rd,
    output logic                    exValid,
    output logic                    exResultSrc,
    output logic                    exMemWrite,
    output logic                    exAluSrc,
    output logic                    exRegWrite,
    output logic                    exBranch,
    output riscvPkg::aluCtrlT       exAluCtrl,
    output logic [dataWidth-1:0]    exImm,
    output logic [regAddrWidth-1:0] exRs1,
    output logic [regAddrWidth-1:0] exRs2,
    output logic [regAddrWidth-1:0] exRd
);
    import riscvPkg::*;

    logic capture;  // load a new decode this edge

    assign capture = ~stall & ~flush;

    // valid and the three side-effect enables
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid    <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
            exBranch   <= 1'b0;
        end else if (flush) begin           // bubble, even during stall
            exValid    <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
            exBranch   <= 1'b0;
        end else if (capture) begin
            exValid    <= inValid;
            exMemWrite <= memWrite & inValid;  // empty slot never writes
            exRegWrite <= regWrite & inValid;
            exBranch   <= branch & inValid;
        end
    end

    // payload, only moves on capture, left as is by flush
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exResultSrc <= 1'b0;
            exAluSrc    <= 1'b0;
            exAluCtrl   <= ALU_ADD;
            exImm       <= '0;
            exRs1       <= '0;
            exRs2       <= '0;
            exRd        <= '0;
        end else if (capture) begin
            exResultSrc <= resultSrc;
            exAluSrc    <= aluSrc;
            exAluCtrl   <= aluCtrl;
            exImm       <= imm;
            exRs1       <= rs1;
            exRs2       <= rs2;
            exRd        <= rd;              // follows instr even when invalid
        end
    end

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
    parameter int dataWidth    = riscvPkg::xlen,
    parameter int regAddrWidth = riscvPkg::regAddrW
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [dataWidth-1:0]    instr,       // fetched instruction
    input  logic                    instrValid,  // instr is real
    input  logic                    stall,       // hold the execute slot
    input  logic                    flush,       // squash the execute slot
    output logic                    exValid,
    output logic                    exResultSrc,
    output logic                    exMemWrite,
    output logic                    exAluSrc,
    output logic                    exRegWrite,
    output logic                    exBranch,
    output riscvPkg::aluCtrlT       exAluCtrl,
    output logic [dataWidth-1:0]    exImm,
    output logic [regAddrWidth-1:0] exRs1,
    output logic [regAddrWidth-1:0] exRs2,
    output logic [regAddrWidth-1:0] exRd
);
    import riscvPkg::*;

    logic                 resultSrc;
    logic                 memWrite;
    logic                 aluSrc;
    logic                 regWrite;
    logic                 branch;
    immSrcT               immSrc;   // main decoder -> imm builder
    aluOpT                aluOp;    // main decoder -> alu decoder
    aluCtrlT              aluCtrl;
    logic [dataWidth-1:0] imm;

    mainDecoder uMainDec (
        .opcode    (instr[6:0]),
        .resultSrc (resultSrc),
        .memWrite  (memWrite),
        .aluSrc    (aluSrc),
        .regWrite  (regWrite),
        .branch    (branch),
        .immSrc    (immSrc),
        .aluOp     (aluOp)
    );

    aluDecoder uAluDec (
        .aluOp    (aluOp),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .opb5     (instr[5]),   // tells R-type from I-type
        .aluCtrl  (aluCtrl)
    );

    immExtend #(
        .dataWidth (dataWidth)
    ) uImmExt (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    idExReg #(
        .dataWidth    (dataWidth),
        .regAddrWidth (regAddrWidth)
    ) uIdEx (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .inValid     (instrValid),
        .resultSrc   (resultSrc),
        .memWrite    (memWrite),
        .aluSrc      (aluSrc),
        .regWrite    (regWrite),
        .branch      (branch),
        .aluCtrl     (aluCtrl),
        .imm         (imm),
        .rs1         (instr[15 +: regAddrWidth]),  // instr[19:15]
        .rs2         (instr[20 +: regAddrWidth]),  // instr[24:20]
        .rd          (instr[7 +: regAddrWidth]),   // instr[11:7]
        .exValid     (exValid),
        .exResultSrc (exResultSrc),
        .exMemWrite  (exMemWrite),
        .exAluSrc    (exAluSrc),
        .exRegWrite  (exRegWrite),
        .exBranch    (exBranch),
        .exAluCtrl   (exAluCtrl),
        .exImm       (exImm),
        .exRs1       (exRs1),
        .exRs2       (exRs2),
        .exRd        (exRd)
    );

endmodule

`default_nettype wire

// File: decodeStage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage_checker #(
    parameter int dataWidth    = riscvPkg::xlen,
    parameter int regAddrWidth = riscvPkg::regAddrW
) (
    input logic                    clk,
    input logic                    arstN,
    input logic                    stall,
    input logic                    flush,
    input logic                    exValid,
    input logic                    exResultSrc,
    input logic                    exMemWrite,
    input logic                    exAluSrc,
    input logic                    exRegWrite,
    input logic                    exBranch,
    input riscvPkg::aluCtrlT       exAluCtrl,
    input logic [dataWidth-1:0]    exImm,
    input logic [regAddrWidth-1:0] exRs1,
    input logic [regAddrWidth-1:0] exRs2,
    input logic [regAddrWidth-1:0] exRd
);
    import riscvPkg::*;

    logic [10+dataWidth+3*regAddrWidth-1:0] exAll;  // every output in one word

    assign exAll = {exValid, exResultSrc, exMemWrite, exAluSrc, exRegWrite, exBranch,
                    exAluCtrl, exImm, exRs1, exRs2, exRd};

    // a slot stores or writes a register, never both
    assert property (@(posedge clk) disable iff (!arstN) !(exMemWrite && exRegWrite))
        else $error("exMemWrite and exRegWrite high together");

    assert property (@(posedge clk) disable iff (!arstN) exBranch |-> exAluCtrl == ALU_SUB)
        else $error("branch slot without a subtract");

    // held slot keeps every output for the stalled edge
    assert property (@(posedge clk) disable iff (!arstN)
                     stall && !flush && exValid |=> $stable(exAll))
        else $error("outputs moved during stall");

endmodule

bind decodeStage decodeStage_checker #(
    .dataWidth    (dataWidth),
    .regAddrWidth (regAddrWidth)
) uChecker (
    .clk         (clk),
    .arstN       (arstN),
    .stall       (stall),
    .flush       (flush),
    .exValid     (exValid),
    .exResultSrc (exResultSrc),
    .exMemWrite  (exMemWrite),
    .exAluSrc    (exAluSrc),
    .exRegWrite  (exRegWrite),
    .exBranch    (exBranch),
    .exAluCtrl   (exAluCtrl),
    .exImm       (exImm),
    .exRs1       (exRs1),
    .exRs2       (exRs2),
    .exRd        (exRd)
);

`default_nettype wire

// File: decodeStage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage_tb;
    import riscvPkg::*;

    localparam int clkPeriod   = 4;    // ns
    localparam int numDirected = 64;   // upper bound on directed cycles
    localparam int numRandom   = 400;
    localparam int numTests    = numDirected + numRandom;

    logic                clk = 1'b0;
    logic                arstN;
    logic [xlen-1:0]     instr;
    logic                instrValid;
    logic                stall;
    logic                flush;
    logic                exValid;
    logic                exResultSrc;
    logic                exMemWrite;
    logic                exAluSrc;
    logic                exRegWrite;
    logic                exBranch;
    aluCtrlT             exAluCtrl;
    logic [xlen-1:0]     exImm;
    logic [regAddrW-1:0] exRs1;
    logic [regAddrW-1:0] exRs2;
    logic [regAddrW-1:0] exRd;

    // expected register contents, reset state to start with
    logic                mValid = 1'b0;
    logic                mResSrc = 1'b0;
    logic                mMemW = 1'b0;
    logic                mAluS = 1'b0;
    logic                mRegW = 1'b0;
    logic                mBr = 1'b0;
    aluCtrlT             mCtrl = ALU_ADD;
    logic [xlen-1:0]     mImm = '0;
    logic [regAddrW-1:0] mRs1 = '0;
    logic [regAddrW-1:0] mRs2 = '0;
    logic [regAddrW-1:0] mRd = '0;
    logic                mKnown = 1'b1;  // data fields are don't care after a flush

    logic [6:0] legalOps [9] = '{LOAD, STORE, OP, BRANCH, OPIMM, AUIPC, LUI, JAL, JALR};
    logic [6:0] immOps [4]   = '{LOAD, STORE, BRANCH, LUI};  // I, S, B, U formats

    decodeStage #(
        .dataWidth    (xlen),
        .regAddrWidth (regAddrW)
    ) i_dut (
        .clk         (clk),
        .arstN       (arstN),
        .instr       (instr),
        .instrValid  (instrValid),
        .stall       (stall),
        .flush       (flush),
        .exValid     (exValid),
        .exResultSrc (exResultSrc),
        .exMemWrite  (exMemWrite),
        .exAluSrc    (exAluSrc),
        .exRegWrite  (exRegWrite),
        .exBranch    (exBranch),
        .exAluCtrl   (exAluCtrl),
        .exImm       (exImm),
        .exRs1       (exRs1),
        .exRs2       (exRs2),
        .exRd        (exRd)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // expected control word, alu op and immediate, straight from the RV32I tables
    function automatic void refDecode(
        input  logic [31:0] i,
        output logic        resSrc,
        output logic        memW,
        output logic        aluS,
        output logic        regW,
        output logic        br,
        output aluCtrlT     ctrl,
        output logic [31:0] imm
    );
        logic isLoad;
        logic isStore;
        logic isOp;
        logic isBr;
        logic isOpImm;
        logic isU;
        logic isJump;
        isLoad  = (i[6:0] == 7'b0000011);
        isStore = (i[6:0] == 7'b0100011);
        isOp    = (i[6:0] == 7'b0110011);
        isBr    = (i[6:0] == 7'b1100011);
        isOpImm = (i[6:0] == 7'b0010011);
        isU     = (i[6:0] == 7'b0010111) || (i[6:0] == 7'b0110111);  // auipc, lui
        isJump  = (i[6:0] == 7'b1101111) || (i[6:0] == 7'b1100111);  // jal, jalr
        resSrc  = isLoad;
        memW    = isStore;
        aluS    = isLoad | isStore | isOpImm | isU | isJump;
        regW    = isLoad | isOp | isOpImm | isU | isJump;
        br      = isBr;
        ctrl    = ALU_ADD;                    // loads, stores, U, jumps, illegal
        if (isBr) begin
            ctrl = ALU_SUB;
        end else if (isOp || isOpImm) begin
            case (i[14:12])
                3'd0: ctrl = (isOp && i[30]) ? ALU_SUB : ALU_ADD;  // no subi
                3'd1: ctrl = ALU_SLL;
                3'd2: ctrl = ALU_SLT;
                3'd3: ctrl = ALU_SLTU;
                3'd4: ctrl = ALU_XOR;
                3'd5: ctrl = i[30] ? ALU_SRA : ALU_SRL;
                3'd6: ctrl = ALU_OR;
                default: ctrl = ALU_AND;
            endcase
        end
        if (isStore) begin
            imm = {{20{i[31]}}, i[31:25], i[11:7]};
        end else if (isBr) begin
            imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        end else if (isU) begin
            imm = {i[31:12], 12'h000};
        end else begin
            imm = {{20{i[31]}}, i[31:20]};   // I format, also jumps and illegal
        end
    endfunction

    // bit 31 and bits 29:25 filled from the register fields for imm variety
    function automatic logic [31:0] makeInstr(input logic [6:0] op, input logic [2:0] f3,
                                             input logic f7b5, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [4:0] rd);
        return {rd[0], f7b5, rs1, rs2, rs1, f3, rd, op};
    endfunction

    task automatic stopWithFailure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkCtrl(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkAluCtrl(input aluCtrlT got, input aluCtrlT exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: exAluCtrl is %s, expected %s", $time, got.name(), exp.name());
            stopWithFailure();
        end
    endtask

    task automatic checkImm(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: exImm is %h, expected %h", $time, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkReg(input string what, input logic [regAddrW-1:0] got,
                            input logic [regAddrW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stopWithFailure();
        end
    endtask

    // one stimulus beat, lands in the DUT at the following edge
    task automatic driveCycle(input logic [31:0] i, input logic v, input logic s, input logic f);
        @(posedge clk);
        instr      <= i;
        instrValid <= v;
        stall      <= s;
        flush      <= f;
    endtask

    // register model, reads the inputs as the DUT sees them at the edge
    always @(posedge clk) begin
        logic    dResSrc;
        logic    dMemW;
        logic    dAluS;
        logic    dRegW;
        logic    dBr;
        aluCtrlT dCtrl;
        logic [31:0] dImm;
        refDecode(instr, dResSrc, dMemW, dAluS, dRegW, dBr, dCtrl, dImm);
        if (!arstN) begin
            {mValid, mResSrc, mMemW, mAluS, mRegW, mBr} = '0;
            mCtrl  = ALU_ADD;
            mImm   = '0;
            mRs1   = '0;
            mRs2   = '0;
            mRd    = '0;
            mKnown = 1'b1;
        end else if (flush) begin           // wins over stall
            {mValid, mMemW, mRegW, mBr} = '0;
            mKnown = 1'b0;
        end else if (!stall) begin
            mValid  = instrValid;
            mMemW   = dMemW & instrValid;   // bubble never writes
            mRegW   = dRegW & instrValid;
            mBr     = dBr & instrValid;
            mResSrc = dResSrc;
            mAluS   = dAluS;
            mCtrl   = dCtrl;
            mImm    = dImm;
            mRs1    = instr[19:15];
            mRs2    = instr[24:20];
            mRd     = instr[11:7];
            mKnown  = 1'b1;
        end
    end

    // outputs are settled mid cycle
    always @(negedge clk) begin
        checkCtrl("exValid", exValid, mValid);
        checkCtrl("exMemWrite", exMemWrite, mMemW);
        checkCtrl("exRegWrite", exRegWrite, mRegW);
        checkCtrl("exBranch", exBranch, mBr);
        if (mKnown) begin
            checkCtrl("exResultSrc", exResultSrc, mResSrc);
            checkCtrl("exAluSrc", exAluSrc, mAluS);
            checkAluCtrl(exAluCtrl, mCtrl);
            checkImm(exImm, mImm);
            checkReg("exRs1", exRs1, mRs1);
            checkReg("exRs2", exRs2, mRs2);
            checkReg("exRd", exRd, mRd);
        end
    end

    initial begin
        #((numTests + 20) * clkPeriod);
        $display("timeout: stimulus did not finish within %0d ns", (numTests + 20) * clkPeriod);
        stopWithFailure();
    end

    initial begin
        logic [31:0] r;
        logic [31:0] k;
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        void'($urandom(32'h8c42));
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        for (int j = 0; j < 10; j++) begin   // nine legal opcodes, then an illegal one
            r = $urandom();
            r[6:0] = (j < 9) ? legalOps[j[3:0]] : 7'b1111111;
            driveCycle(r, 1'b1, 1'b0, 1'b0);
        end
        for (int j = 0; j < 16; j++) begin   // every funct3, both funct7b5
            driveCycle(makeInstr(OP, j[2:0], j[3], 5'(j), 5'(j + 1), 5'(31 - j)), 1'b1, 1'b0, 1'b0);
            driveCycle(makeInstr(OPIMM, j[2:0], j[3], 5'(j + 3), 5'(j), 5'(j)), 1'b1, 1'b0, 1'b0);
        end
        for (int j = 0; j < 8; j++) begin    // each format with both sign bits
            r = $urandom();
            r[6:0] = immOps[j[1:0]];
            r[31]  = j[2];
            driveCycle(r, 1'b1, 1'b0, 1'b0);
        end
        driveCycle(makeInstr(OP, 3'b000, 1'b1, 5'd1, 5'd2, 5'd3), 1'b1, 1'b0, 1'b0);
        repeat (3) begin
            r = $urandom();
            driveCycle(r, 1'b1, 1'b1, 1'b0);  // sub stays put
        end
        driveCycle(32'h0, 1'b1, 1'b1, 1'b1);
        driveCycle(makeInstr(STORE, 3'b010, 1'b1, 5'd10, 5'd11, 5'd12), 1'b1, 1'b0, 1'b0);
        driveCycle(32'h0, 1'b1, 1'b0, 1'b1);
        driveCycle(makeInstr(BRANCH, 3'b001, 1'b0, 5'd13, 5'd14, 5'd15), 1'b1, 1'b0, 1'b0);
        driveCycle(32'h0, 1'b1, 1'b1, 1'b1);
        driveCycle(makeInstr(OP, 3'b111, 1'b0, 5'd4, 5'd5, 5'd6), 1'b0, 1'b0, 1'b0);
        driveCycle(makeInstr(LOAD, 3'b010, 1'b0, 5'd7, 5'd8, 5'd9), 1'b0, 1'b0, 1'b0);
        for (int n = 0; n < numRandom; n++) begin
            r = $urandom();
            k = $urandom();
            if (k[2:0] != 3'b000) begin
                r[6:0] = legalOps[4'(k[31:4] % 9)];  // mostly legal
            end
            driveCycle(r, k[10:8] != 3'b000, k[13:11] == 3'b000, k[17:14] == 4'b0000);
        end
        driveCycle(32'h0, 1'b0, 1'b0, 1'b0);
        driveCycle(32'h0, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
riscvPkg.sv
mainDecoder.sv
aluDecoder.sv
immExtend.sv
idExReg.sv
decodeStage.sv
decodeStage_checker.sv
decodeStage_tb.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStage_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := CHECKS FAILED
PASS_MSG := ALL CHECKS PASSED
SOURCES  := $(filter-out +incdir%,$(shell cat $(FILELIST)))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test failed, no verdict in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
